/* rtl/led_ctrl_pkg.sv */
`default_nettype none

package led_ctrl_pkg;

    // one serial or frame buffer byte
    typedef logic [7:0] byte_t;

    // colour plane commands, upper case enables and lower case disables
    localparam byte_t cmd_red_on     = "R";
    localparam byte_t cmd_red_off    = "r";
    localparam byte_t cmd_green_on   = "G";
    localparam byte_t cmd_green_off  = "g";
    localparam byte_t cmd_blue_on    = "B";
    localparam byte_t cmd_blue_off   = "b";

    // brightness plane toggles, 1 is the most significant plane
    localparam byte_t cmd_plane_1    = "1";
    localparam byte_t cmd_plane_2    = "2";
    localparam byte_t cmd_plane_3    = "3";
    localparam byte_t cmd_plane_4    = "4";
    localparam byte_t cmd_plane_5    = "5";
    localparam byte_t cmd_plane_6    = "6";
    localparam byte_t cmd_dim_all    = "0";
    localparam byte_t cmd_bright_all = "9";

    // start of a line load, followed by a row byte and the line data
    localparam byte_t cmd_line       = "L";

    localparam logic [2:0] rgb_reset = 3'b111;
    localparam int brightness_bits   = 6;

endpackage

`default_nettype wire

/* rtl/uart_rx.sv */
`default_nettype none
`timescale 1ns/1ns

module uart_rx
    import led_ctrl_pkg::*;
#(
    parameter int ticks_per_bit = 9
) (
    input  wire   clk_in,
    input  wire   reset,
    input  wire   rx,
    output byte_t rx_data,
    output logic  rx_valid,
    output logic  rx_busy
);

    localparam int cnt_w = $clog2(ticks_per_bit);
    localparam logic [cnt_w-1:0] tick_last = cnt_w'(ticks_per_bit - 1);
    localparam logic [cnt_w-1:0] tick_half = cnt_w'(ticks_per_bit / 2);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] tick_cnt;
    logic [2:0]       bit_cnt;
    byte_t            shift_reg;
    logic             bit_strobe;

    // two flop synchroniser, line idles high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // centre of a data bit
    assign bit_strobe = (state == st_data) && (tick_cnt == tick_last);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    tick_cnt <= '0;
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // recheck the start bit at its centre
                    if (tick_cnt == tick_half) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        if (rx_sync) begin
                            state <= st_idle;
                        end else begin
                            state <= st_data;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (tick_cnt == tick_last) begin
                        tick_cnt <= '0;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    // a low stop bit drops the byte silently
                    if (tick_cnt == tick_last) begin
                        tick_cnt <= '0;
                        state    <= st_idle;
                        rx_valid <= rx_sync;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk_in) begin
        if (bit_strobe) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign rx_data = shift_reg;
    assign rx_busy = (state != st_idle);

    a_valid_single: assert property (@(posedge clk_in) disable iff (reset)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

/* rtl/command_decoder.sv */
`default_nettype none
`timescale 1ns/1ns

module command_decoder
    import led_ctrl_pkg::*;
#(
    parameter int pixel_width     = 64,
    parameter int pixel_height    = 32,
    parameter int bytes_per_pixel = 2
) (
    input  wire                                                      clk_in,
    input  wire                                                      reset,
    input  wire byte_t                                               rx_data,
    input  wire                                                      rx_valid,
    output logic [2:0]                                               rgb_enable,
    output logic [brightness_bits-1:0]                               brightness_enable,
    output logic                                                     wr_en,
    output logic [$clog2(pixel_width*pixel_height*bytes_per_pixel)-1:0] wr_addr,
    output byte_t                                                    wr_data
);

    localparam int line_bytes = pixel_width * bytes_per_pixel;
    localparam int depth      = line_bytes * pixel_height;
    localparam int addr_w     = $clog2(depth);
    localparam int row_w      = $clog2(pixel_height);
    localparam int col_w      = $clog2(line_bytes);

    localparam logic [col_w-1:0] col_last = col_w'(line_bytes - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_row,
        st_load
    } dec_state_t;

    dec_state_t       state;
    logic [row_w-1:0] row;
    logic [col_w-1:0] col;
    logic             load_byte;

    // every byte in the load state is line data, even a command code
    assign load_byte = rx_valid && (state == st_load);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state             <= st_idle;
            col               <= '0;
            wr_en             <= 1'b0;
            rgb_enable        <= rgb_reset;
            brightness_enable <= {brightness_bits{1'b1}};
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    st_idle: begin
                        case (rx_data)
                            cmd_red_on: begin
                                rgb_enable[0] <= 1'b1;
                            end
                            cmd_red_off: begin
                                rgb_enable[0] <= 1'b0;
                            end
                            cmd_green_on: begin
                                rgb_enable[1] <= 1'b1;
                            end
                            cmd_green_off: begin
                                rgb_enable[1] <= 1'b0;
                            end
                            cmd_blue_on: begin
                                rgb_enable[2] <= 1'b1;
                            end
                            cmd_blue_off: begin
                                rgb_enable[2] <= 1'b0;
                            end
                            cmd_plane_1: begin
                                brightness_enable[brightness_bits-1] <=
                                    ~brightness_enable[brightness_bits-1];
                            end
                            cmd_plane_2: begin
                                brightness_enable[brightness_bits-2] <=
                                    ~brightness_enable[brightness_bits-2];
                            end
                            cmd_plane_3: begin
                                brightness_enable[brightness_bits-3] <=
                                    ~brightness_enable[brightness_bits-3];
                            end
                            cmd_plane_4: begin
                                brightness_enable[brightness_bits-4] <=
                                    ~brightness_enable[brightness_bits-4];
                            end
                            cmd_plane_5: begin
                                brightness_enable[brightness_bits-5] <=
                                    ~brightness_enable[brightness_bits-5];
                            end
                            cmd_plane_6: begin
                                brightness_enable[brightness_bits-6] <=
                                    ~brightness_enable[brightness_bits-6];
                            end
                            cmd_dim_all: begin
                                brightness_enable <= '0;
                            end
                            cmd_bright_all: begin
                                brightness_enable <= {brightness_bits{1'b1}};
                            end
                            cmd_line: begin
                                state <= st_row;
                            end
                            default: begin
                                // unknown characters are ignored
                            end
                        endcase
                    end
                    st_row: begin
                        col   <= '0;
                        state <= st_load;
                    end
                    st_load: begin
                        wr_en <= 1'b1;
                        if (col == col_last) begin
                            state <= st_idle;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

    // row wraps on the low bits of the row byte
    always_ff @(posedge clk_in) begin
        if (rx_valid && (state == st_row)) begin
            row <= rx_data[row_w-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (load_byte) begin
            wr_data <= rx_data;
            wr_addr <= addr_w'(row) * addr_w'(line_bytes) + addr_w'(col);
        end
    end

    // a write always comes from a byte taken in the load state
    a_wr_from_load: assert property (@(posedge clk_in) disable iff (reset)
        wr_en |-> ($past(state) == st_load) && $past(rx_valid));

    a_wr_in_range: assert property (@(posedge clk_in) disable iff (reset)
        wr_en |-> (wr_addr < depth));

endmodule

`default_nettype wire

/* rtl/frame_buffer.sv */
`default_nettype none
`timescale 1ns/1ns

module frame_buffer
    import led_ctrl_pkg::*;
#(
    parameter int pixel_width     = 64,
    parameter int pixel_height    = 32,
    parameter int bytes_per_pixel = 2
) (
    input  wire                                                      clk_in,
    input  wire                                                      wr_en,
    input  wire [$clog2(pixel_width*pixel_height*bytes_per_pixel)-1:0] wr_addr,
    input  wire byte_t                                               wr_data,
    input  wire [$clog2(pixel_width*pixel_height*bytes_per_pixel)-1:0] rd_addr,
    output byte_t                                                    rd_data
);

    localparam int depth = pixel_width * pixel_height * bytes_per_pixel;

    // one byte per entry, rows stored back to back
    byte_t mem [depth];

    // write port owned by the command decoder
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, same address write returns the old byte
    always_ff @(posedge clk_in) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* rtl/led_ctrl_top.sv */
`default_nettype none
`timescale 1ns/1ns

module led_ctrl_top
    import led_ctrl_pkg::*;
#(
    parameter int ticks_per_bit   = 9,
    parameter int pixel_width     = 64,
    parameter int pixel_height    = 32,
    parameter int bytes_per_pixel = 2
) (
    input  wire                                                      clk_in,
    input  wire                                                      reset,
    input  wire                                                      uart_rx,
    output wire                                                      rx_busy,
    output wire [2:0]                                                rgb_enable,
    output wire [brightness_bits-1:0]                                brightness_enable,
    input  wire [$clog2(pixel_width*pixel_height*bytes_per_pixel)-1:0] rd_addr,
    output wire byte_t                                               rd_data
);

    localparam int addr_w = $clog2(pixel_width * pixel_height * bytes_per_pixel);

    // receiver to decoder
    wire byte_t rx_data;
    wire        rx_valid;

    // decoder to frame buffer write port
    wire              wr_en;
    wire [addr_w-1:0] wr_addr;
    wire byte_t       wr_data;

    uart_rx #(
        .ticks_per_bit (ticks_per_bit)
    ) i_uart_rx (
        .clk_in   (clk_in),
        .reset    (reset),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_busy  (rx_busy)
    );

    command_decoder #(
        .pixel_width     (pixel_width),
        .pixel_height    (pixel_height),
        .bytes_per_pixel (bytes_per_pixel)
    ) i_command_decoder (
        .clk_in            (clk_in),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .wr_en             (wr_en),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data)
    );

    frame_buffer #(
        .pixel_width     (pixel_width),
        .pixel_height    (pixel_height),
        .bytes_per_pixel (bytes_per_pixel)
    ) i_frame_buffer (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 8
) (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
        forever #(period_ns / 2) clk_in = ~clk_in;
    end

    // release on a falling edge so the first active edge sees a clean low
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* verif/led_ctrl_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module led_ctrl_tb
    import led_ctrl_pkg::*;
;

    localparam int ticks_per_bit   = 8;
    localparam int pixel_width     = 8;
    localparam int pixel_height    = 4;
    localparam int bytes_per_pixel = 2;
    localparam int line_bytes      = pixel_width * bytes_per_pixel;
    localparam int depth           = line_bytes * pixel_height;
    localparam int addr_w          = $clog2(depth);
    localparam int busy_timeout    = 40 * ticks_per_bit;
    localparam int settle_cycles   = 3;

    logic                       clk_in;
    logic                       reset;
    logic                       serial_line;
    logic                       rx_busy;
    logic [2:0]                 rgb_enable;
    logic [brightness_bits-1:0] brightness_enable;
    logic [addr_w-1:0]          rd_addr;
    byte_t                      rd_data;

    // expected state, built from the command rules
    logic [2:0]                 model_rgb;
    logic [brightness_bits-1:0] model_bright;
    byte_t                      exp_mem [depth];
    logic [31:0]                lcg_state;
    int                         error_count;
    int                         check_count;
    logic                       timed_out;

    tb_clock_gen #(
        .period_ns    (100),
        .reset_cycles (8)
    ) i_clock_gen (
        .clk_in (clk_in),
        .reset  (reset)
    );

    led_ctrl_top #(
        .ticks_per_bit   (ticks_per_bit),
        .pixel_width     (pixel_width),
        .pixel_height    (pixel_height),
        .bytes_per_pixel (bytes_per_pixel)
    ) i_dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .uart_rx           (serial_line),
        .rx_busy           (rx_busy),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rd_addr           (rd_addr),
        .rd_data           (rd_data)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR %s: expected %0h, actual %0h", test_name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        timed_out = 1'b1;
        $display("timeout: %s", what);
    endtask

    // 8N1 frame, lsb first, then wait until the receiver is idle again
    task automatic send_byte(input byte_t value);
        int cycles;
        if (timed_out) begin
            return;
        end
        serial_line = 1'b0;
        repeat (ticks_per_bit) @(negedge clk_in);
        for (int i = 0; i < 8; i++) begin
            serial_line = value[i];
            repeat (ticks_per_bit) @(negedge clk_in);
        end
        serial_line = 1'b1;
        repeat (ticks_per_bit) @(negedge clk_in);
        cycles = 0;
        while (rx_busy && cycles < busy_timeout) begin
            @(negedge clk_in);
            cycles++;
        end
        if (rx_busy) begin
            report_timeout("rx_busy stayed high after a serial byte");
        end
        repeat (settle_cycles) @(negedge clk_in);
    endtask

    // idle state command rules: upper case sets, lower case clears, digits toggle planes
    task automatic apply_model(input byte_t c);
        int plane;
        case (c)
            cmd_red_on:     model_rgb[0] = 1'b1;
            cmd_red_off:    model_rgb[0] = 1'b0;
            cmd_green_on:   model_rgb[1] = 1'b1;
            cmd_green_off:  model_rgb[1] = 1'b0;
            cmd_blue_on:    model_rgb[2] = 1'b1;
            cmd_blue_off:   model_rgb[2] = 1'b0;
            cmd_dim_all:    model_bright = '0;
            cmd_bright_all: model_bright = '1;
            default: begin
                if (c >= cmd_plane_1 && c <= cmd_plane_6) begin
                    plane = int'(c) - int'(cmd_plane_1);
                    model_bright[brightness_bits-1-plane] =
                        ~model_bright[brightness_bits-1-plane];
                end
            end
        endcase
    endtask

    task automatic check_enables(input string test_name);
        check_value(test_name, 32'(model_rgb), 32'(rgb_enable));
        check_value(test_name, 32'(model_bright), 32'(brightness_enable));
    endtask

    task automatic send_command(input byte_t c, input string test_name);
        send_byte(c);
        apply_model(c);
        check_enables(test_name);
    endtask

    // L, row byte, then one full line; enables must not move
    task automatic load_line(input byte_t row_byte, input string test_name);
        byte_t data;
        int    base;
        base = (int'(row_byte) % pixel_height) * line_bytes;
        send_byte(cmd_line);
        check_enables(test_name);
        send_byte(row_byte);
        check_enables(test_name);
        for (int k = 0; k < line_bytes; k++) begin
            lcg_state = lcg_step(lcg_state);
            data = lcg_state[23:16];
            // command codes inside a line are plain data
            if (k == 3) begin
                data = cmd_red_on;
            end else if (k == 7) begin
                data = cmd_dim_all;
            end else if (k == 12) begin
                data = cmd_line;
            end
            send_byte(data);
            exp_mem[base + k] = data;
            check_enables(test_name);
        end
    endtask

    task automatic read_check(input int first, input int last, input string test_name);
        for (int a = first; a <= last; a++) begin
            rd_addr = addr_w'(a);
            @(negedge clk_in);
            check_value(test_name, 32'(exp_mem[a]), 32'(rd_data));
        end
    endtask

    task automatic test_reset_values();
        check_value("reset_values", 32'(rgb_reset), 32'(rgb_enable));
        check_value("reset_values", 32'({brightness_bits{1'b1}}), 32'(brightness_enable));
        check_value("reset_values", 32'(1'b0), 32'(rx_busy));
    endtask

    task automatic test_colour_commands();
        send_command(cmd_red_off, "colour_commands");
        send_command(cmd_green_off, "colour_commands");
        send_command(cmd_blue_off, "colour_commands");
        check_value("colour_commands", 32'(3'b000), 32'(rgb_enable));
        send_command(cmd_green_on, "colour_commands");
        check_value("colour_commands", 32'(3'b010), 32'(rgb_enable));
    endtask

    task automatic test_brightness_commands();
        send_command(cmd_dim_all, "brightness_commands");
        check_value("brightness_commands", 32'(6'b000000), 32'(brightness_enable));
        send_command(cmd_plane_1, "brightness_commands");
        send_command(cmd_plane_6, "brightness_commands");
        check_value("brightness_commands", 32'(6'b100001), 32'(brightness_enable));
        send_command(cmd_plane_6, "brightness_commands");
        check_value("brightness_commands", 32'(6'b100000), 32'(brightness_enable));
        send_command(cmd_bright_all, "brightness_commands");
        check_value("brightness_commands", 32'(6'b111111), 32'(brightness_enable));
    endtask

    task automatic test_line_load();
        load_line(8'd2, "line_load");
        read_check(2 * line_bytes, 3 * line_bytes - 1, "line_load");
    endtask

    task automatic test_row_wrap();
        logic [2:0]                 saved_rgb;
        logic [brightness_bits-1:0] saved_bright;
        // 37 wraps to row 1
        load_line(8'd37, "row_wrap");
        read_check(line_bytes, 2 * line_bytes - 1, "row_wrap");
        read_check(2 * line_bytes, 3 * line_bytes - 1, "row_wrap");
        saved_rgb = model_rgb;
        saved_bright = model_bright;
        send_command("x", "row_wrap");
        send_command(8'h0a, "row_wrap");
        send_command("z", "row_wrap");
        send_command(8'h00, "row_wrap");
        check_value("row_wrap", 32'(saved_rgb), 32'(rgb_enable));
        check_value("row_wrap", 32'(saved_bright), 32'(brightness_enable));
    endtask

    initial begin
        int cycles;
        serial_line = 1'b1;
        rd_addr = '0;
        model_rgb = rgb_reset;
        model_bright = '1;
        lcg_state = 32'h8f2b78d0;
        error_count = 0;
        check_count = 0;
        timed_out = 1'b0;
        for (int a = 0; a < depth; a++) begin
            exp_mem[a] = '0;
        end

        cycles = 0;
        @(negedge clk_in);
        while (reset && cycles < 50) begin
            @(negedge clk_in);
            cycles++;
        end
        if (reset) begin
            report_timeout("reset was never released");
        end else begin
            @(negedge clk_in);
            test_reset_values();
            test_colour_commands();
            test_brightness_commands();
            test_line_load();
            test_row_wrap();
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/led_ctrl_pkg.sv
rtl/uart_rx.sv
rtl/command_decoder.sv
rtl/frame_buffer.sv
rtl/led_ctrl_top.sv
verif/tb_clock_gen.sv
verif/led_ctrl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the LED controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f files.f --top-module led_ctrl_tb \
    -Mdir "$build_dir" -o led_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/led_ctrl_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
